// ==== lsu_pipe.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/dmem_request_former.sv
hw/lsu_stage_buffer.sv
hw/load_result_extractor.sv
hw/lsu_top.sv
verification/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_pipe

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/dmem_request_former.sv
      - hw/lsu_stage_buffer.sv
      - hw/load_result_extractor.sv
      - hw/lsu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/lsu_tb.sv

// ==== verification/lsu_tb.sv ====
`timescale 1ns/100ps

`include "lsu_defines.svh"

module lsu_tb;

    // Directed operations plus the random mix
    localparam int N_DIRECTED  = 39;
    localparam int N_RANDOM    = 200;
    localparam int N_OPS       = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_NS = N_OPS * 4 * 40 + 2000;

    typedef logic [`LSU_XLEN-1:0] word_mem_t [256];

    logic                 i_clk;
    logic                 i_rst;
    lsu_pkg::lsu_req_t    i_req;
    logic                 i_stall;
    logic [`LSU_XLEN-1:0] i_dmem_rdata = '0;
    lsu_pkg::dmem_req_t   o_dmem;
    lsu_pkg::retire_t     o_retire;

    word_mem_t sram;
    // Reference copy updated when a store is accepted
    word_mem_t shadow;
    lsu_pkg::retire_t exp_q[$];
    int acc_cycle_q[$];
    int acc_stall_q[$];
    int cycle_cnt    = 0;
    int stall_cnt    = 0;
    int value_errors = 0;
    int seq_errors   = 0;
    int seed         = 32'h9843_1b71;
    logic stall_on   = 1'b0;
    lsu_pkg::mem_op_e op_table [8] = '{lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW,
        lsu_pkg::OP_LBU, lsu_pkg::OP_LHU, lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};

    lsu_top u_lsu_top (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (i_req),
        .i_stall      (i_stall),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem       (o_dmem),
        .o_retire     (o_retire)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // ========================================
    // SRAM model and cycle counters
    // ========================================

    // Masked write at the edge
    // Read word held until the next read
    always @(posedge i_clk) begin
        for (int b = 0; b < 4; b++) begin
            if (o_dmem.wen && o_dmem.mask[b]) begin
                sram[o_dmem.addr[9:2]][8*b +: 8] = o_dmem.wdata[8*b +: 8];
            end
        end
        if (o_dmem.ren) begin
            i_dmem_rdata <= #2 sram[o_dmem.addr[9:2]];
        end
        cycle_cnt <= cycle_cnt + 1;
        stall_cnt <= stall_cnt + i_stall;
    end

    // ========================================
    // Reference model
    // ========================================

    function automatic int op_bytes(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::OP_LW, lsu_pkg::OP_SW:                  return 4;
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: return 2;
            default:                                         return 1;
        endcase
    endfunction

    function automatic lsu_pkg::retire_t expected_retire(input lsu_pkg::lsu_req_t req,
                                                         input word_mem_t mem);
        lsu_pkg::retire_t r;
        logic [1:0]       off;
        logic             load;
        logic [31:0]      lane;
        int               n;
        n    = op_bytes(req.op);
        off  = req.addr[1:0];
        load = !(req.op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW});
        // Addressed byte moved down to lane 0
        lane = mem[req.addr[9:2]] >> (8 * off);
        r    = '0;
        r.valid      = 1'b1;
        r.trap       = (n == 2 && off[0]) || (n == 4 && off != 2'd0);
        r.dmem_addr  = {req.addr[31:2], 2'b00};
        r.dmem_mask  = (n == 4) ? 4'hf : (n == 2) ? (4'h3 << off) : (4'h1 << off);
        r.dmem_ren   = load && !r.trap;
        r.dmem_wen   = !load && !r.trap;
        r.dmem_wdata = req.wdata << (8 * off);
        r.dmem_rdata = mem[req.addr[9:2]];
        if (r.dmem_ren) begin
            r.rd_waddr = req.rd;
            case (req.op)
                lsu_pkg::OP_LB:  r.rd_wdata = {{24{lane[7]}}, lane[7:0]};
                lsu_pkg::OP_LBU: r.rd_wdata = {24'h0, lane[7:0]};
                lsu_pkg::OP_LH:  r.rd_wdata = {{16{lane[15]}}, lane[15:0]};
                lsu_pkg::OP_LHU: r.rd_wdata = {16'h0, lane[15:0]};
                default:         r.rd_wdata = lane;
            endcase
        end
        return r;
    endfunction

    function automatic lsu_pkg::dmem_req_t dmem_of(input lsu_pkg::retire_t r);
        return '{addr: r.dmem_addr, mask: r.dmem_mask, ren: r.dmem_ren,
                 wen: r.dmem_wen, wdata: r.dmem_wdata};
    endfunction

    // ========================================
    // Compare tasks
    // ========================================

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h exp %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_dmem(input lsu_pkg::dmem_req_t got, input lsu_pkg::dmem_req_t exp);
        compare_field("o_dmem.ren", got.ren, exp.ren);
        compare_field("o_dmem.wen", got.wen, exp.wen);
        compare_field("o_dmem.addr", got.addr, exp.addr);
        compare_field("o_dmem.mask", got.mask, exp.mask);
        compare_field("o_dmem.wdata", got.wdata, exp.wdata);
    endtask

    task automatic check_retire(input lsu_pkg::retire_t got, input lsu_pkg::retire_t exp);
        logic [31:0] lanes;
        // Read word only matters in the lanes a load used
        lanes = {{8{exp.dmem_mask[3]}}, {8{exp.dmem_mask[2]}},
                 {8{exp.dmem_mask[1]}}, {8{exp.dmem_mask[0]}}};
        lanes = exp.dmem_ren ? lanes : 32'h0;
        compare_field("o_retire.trap", got.trap, exp.trap);
        compare_field("o_retire.rd_waddr", got.rd_waddr, exp.rd_waddr);
        if (!exp.trap) begin
            compare_field("o_retire.rd_wdata", got.rd_wdata, exp.rd_wdata);
        end
        compare_field("o_retire.dmem_addr", got.dmem_addr, exp.dmem_addr);
        compare_field("o_retire.dmem_mask", got.dmem_mask, exp.dmem_mask);
        compare_field("o_retire.dmem_ren", got.dmem_ren, exp.dmem_ren);
        compare_field("o_retire.dmem_wen", got.dmem_wen, exp.dmem_wen);
        compare_field("o_retire.dmem_wdata", got.dmem_wdata, exp.dmem_wdata);
        compare_field("o_retire.dmem_rdata", got.dmem_rdata & lanes, exp.dmem_rdata & lanes);
    endtask

    // Expected record queued for each accepted operation
    always @(negedge i_clk) begin
        lsu_pkg::retire_t exp_rec;
        logic             accept;
        accept  = i_req.valid && !i_stall;
        exp_rec = expected_retire(i_req, shadow);
        if (!accept) begin
            exp_rec.dmem_ren = 1'b0;
            exp_rec.dmem_wen = 1'b0;
        end
        check_dmem(o_dmem, dmem_of(exp_rec));
        if (accept) begin
            exp_q.push_back(exp_rec);
            acc_cycle_q.push_back(cycle_cnt);
            acc_stall_q.push_back(stall_cnt);
            for (int b = 0; b < 4; b++) begin
                if (exp_rec.dmem_wen && exp_rec.dmem_mask[b]) begin
                    shadow[i_req.addr[9:2]][8*b +: 8] = exp_rec.dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    // Retires come in order and once each
    // Latency is 2 plus the stalled cycles
    always @(negedge i_clk) begin
        lsu_pkg::retire_t exp_rec;
        int               latency;
        if (o_retire.valid !== 1'b0) begin
            if (i_stall) begin
                $display("retire reported while the pipeline is stalled");
                seq_errors++;
            end
            if (exp_q.size() == 0) begin
                $display("retire seen with no operation outstanding");
                seq_errors++;
            end else begin
                exp_rec = exp_q.pop_front();
                latency = cycle_cnt - acc_cycle_q.pop_front();
                check_retire(o_retire, exp_rec);
                compare_field("retire latency", latency, 2 + stall_cnt - acc_stall_q.pop_front());
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    // Holds the request until an edge with stall low takes it
    task automatic send_op(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [4:0] rd);
        logic taken;
        i_req = '{valid: 1'b1, op: op, addr: addr, wdata: wdata, rd: rd};
        do begin
            @(posedge i_clk);
            taken = !i_stall;
            #2;
            i_stall = stall_on && (($random(seed) & 3) == 0);
        end while (!taken);
        i_req.valid = 1'b0;
    endtask

    initial begin
        int               r;
        logic [31:0]      a;
        lsu_pkg::mem_op_e op;
        i_rst   = 1'b1;
        i_stall = 1'b0;
        i_req   = '0;
        // Every byte of the fill has a different mix of the index bits
        for (int i = 0; i < 256; i++) begin
            sram[i]   = {i[7:0] ^ 8'h9c, ~i[7:0], i[7:0] | 8'h80, i[7:0]};
            shadow[i] = sram[i];
        end
        repeat (2) @(posedge i_clk);
        #2 i_rst = 1'b0;
        repeat (3) @(posedge i_clk);
        #2;
        send_op(lsu_pkg::OP_SW, 32'h40, 32'hdead_beef, 5'd1);
        send_op(lsu_pkg::OP_LW, 32'h40, 32'h0, 5'd2);
        // Sub-word stores each followed by a full word read back
        for (int k = 0; k < 4; k++) begin
            send_op(lsu_pkg::OP_SB, 32'h80 + k, 32'hcafe_ba00 + k, 5'd3);
            send_op(lsu_pkg::OP_LW, 32'h80, 32'h0, 5'd4);
        end
        for (int k = 0; k < 4; k += 2) begin
            send_op(lsu_pkg::OP_SH, 32'h90 + k, 32'hf00d_c3a5 + k, 5'd5);
            send_op(lsu_pkg::OP_LW, 32'h90, 32'h0, 5'd6);
        end
        // Extension over bytes with the top bit both set and clear
        send_op(lsu_pkg::OP_SW, 32'h100, 32'h80f0_7f81, 5'd7);
        for (int k = 0; k < 4; k++) begin
            send_op(lsu_pkg::OP_LB, 32'h100 + k, 32'h0, 5'd8);
            send_op(lsu_pkg::OP_LBU, 32'h100 + k, 32'h0, 5'd9);
            if (k[0] == 1'b0) begin
                send_op(lsu_pkg::OP_LH, 32'h100 + k, 32'h0, 5'd10);
                send_op(lsu_pkg::OP_LHU, 32'h100 + k, 32'h0, 5'd11);
            end
        end
        // Misaligned accesses leave the word unchanged
        send_op(lsu_pkg::OP_SW, 32'h140, 32'h1234_5678, 5'd12);
        for (int k = 1; k < 4; k++) begin
            send_op(lsu_pkg::OP_LW, 32'h140 + k, 32'h0, 5'd13);
            send_op(lsu_pkg::OP_SW, 32'h140 + k, 32'hffff_ffff, 5'd14);
            if (k[0]) begin
                send_op(lsu_pkg::OP_LH, 32'h140 + k, 32'h0, 5'd15);
                send_op(lsu_pkg::OP_SH, 32'h140 + k, 32'hffff_ffff, 5'd16);
            end
        end
        send_op(lsu_pkg::OP_LW, 32'h140, 32'h0, 5'd17);
        // Random mix under random stall with some addresses forced aligned
        stall_on = 1'b1;
        repeat (N_RANDOM) begin
            r  = $random(seed);
            op = op_table[r[2:0]];
            a  = {22'h0, r[12:3]};
            if (r[13]) begin
                a = a & ~(op_bytes(op) - 1);
            end
            send_op(op, a, $random(seed), r[18:14]);
        end
        stall_on = 1'b0;
        i_stall  = 1'b0;
        for (int k = 0; k < 8 && exp_q.size() != 0; k++) begin
            @(posedge i_clk);
        end
        if (exp_q.size() != 0) begin
            $display("%0d operations never retired", exp_q.size());
            seq_errors++;
        end
        $display("errors: %0d value mismatches, %0d sequence errors", value_errors, seq_errors);
        if (value_errors + seq_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the operations did not complete in time");
        $display("errors: %0d value mismatches, %0d sequence errors", value_errors, seq_errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/100ps

`include "lsu_defines.svh"

module lsu_top (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  lsu_pkg::lsu_req_t    i_req,
    input  logic                 i_stall,
    input  logic [`LSU_XLEN-1:0] i_dmem_rdata,
    output lsu_pkg::dmem_req_t   o_dmem,
    output lsu_pkg::retire_t     o_retire
);

    // Record from the former into the access stage
    lsu_pkg::access_rec_t issue_rec;
    // Retire stage contents and its read word
    lsu_pkg::access_rec_t retire_rec;
    logic [`LSU_XLEN-1:0] retire_rdata;

    // ========================================
    // Request former, buffer, extractor
    // ========================================

    dmem_request_former u_former (
        .i_req   (i_req),
        .i_stall (i_stall),
        .o_dmem  (o_dmem),
        .o_rec   (issue_rec)
    );

    lsu_stage_buffer u_buffer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (i_stall),
        .i_rec        (issue_rec),
        .i_dmem_rdata (i_dmem_rdata),
        .o_rec        (retire_rec),
        .o_rdata      (retire_rdata)
    );

    load_result_extractor u_extractor (
        .i_rec    (retire_rec),
        .i_rdata  (retire_rdata),
        .i_stall  (i_stall),
        .o_retire (o_retire)
    );

endmodule

// ==== hw/load_result_extractor.sv ====
`timescale 1ns/100ps

`include "lsu_defines.svh"

module load_result_extractor (
    input  lsu_pkg::access_rec_t i_rec,
    input  logic [`LSU_XLEN-1:0] i_rdata,
    input  logic                 i_stall,
    output lsu_pkg::retire_t     o_retire
);

    // Read word with the addressed byte moved to lane 0
    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] ext;
    logic [2:0]           size;
    logic                 sext;
    logic                 is_ld;
    // Load that really wrote a register
    logic                 ld_ok;

    // ========================================
    // Load data alignment and extension
    // ========================================

    always_comb begin
        size    = lsu_pkg::access_size(i_rec.op);
        sext    = lsu_pkg::is_signed_load(i_rec.op);
        is_ld   = ~lsu_pkg::is_store(i_rec.op);
        ld_ok   = is_ld & ~i_rec.trap;
        shifted = i_rdata >> (i_rec.offset * `LSU_BYTE_W);

        // Upper bits take the sign only for LB and LH
        case (size)
            3'd1: begin
                ext = {{(`LSU_XLEN-`LSU_BYTE_W){sext & shifted[`LSU_BYTE_W-1]}},
                       shifted[`LSU_BYTE_W-1:0]};
            end
            3'd2: begin
                ext = {{(`LSU_XLEN-2*`LSU_BYTE_W){sext & shifted[2*`LSU_BYTE_W-1]}},
                       shifted[2*`LSU_BYTE_W-1:0]};
            end
            default: begin
                ext = shifted;
            end
        endcase
    end

    // ========================================
    // Retire record
    // ========================================

    always_comb begin
        // No retire while the pipeline is frozen
        o_retire.valid      = i_rec.valid & ~i_stall;
        o_retire.trap       = i_rec.trap;

        // Stores and trapped loads report no register write
        o_retire.rd_waddr   = ld_ok ? i_rec.rd : '0;
        o_retire.rd_wdata   = is_ld ? ext : '0;

        // Mirror of the request issued in the access cycle
        o_retire.dmem_addr  = i_rec.dmem.addr;
        o_retire.dmem_mask  = i_rec.dmem.mask;
        o_retire.dmem_ren   = i_rec.dmem.ren;
        o_retire.dmem_wen   = i_rec.dmem.wen;
        o_retire.dmem_wdata = i_rec.dmem.wdata;
        // raw word, lanes outside the mask are don't care
        o_retire.dmem_rdata = i_rdata;
    end

endmodule

// ==== hw/lsu_stage_buffer.sv ====
`timescale 1ns/100ps

`include "lsu_defines.svh"

module lsu_stage_buffer (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_stall,
    input  lsu_pkg::access_rec_t i_rec,
    input  logic [`LSU_XLEN-1:0] i_dmem_rdata,
    output lsu_pkg::access_rec_t o_rec,
    output logic [`LSU_XLEN-1:0] o_rdata
);

    // ========================================
    // Stage state
    // ========================================

    // Access and retire stage records
    // The valid bit inside marks a filled stage
    lsu_pkg::access_rec_t acc_q;
    lsu_pkg::access_rec_t ret_q;

    // Read word belonging to the retire stage
    logic [`LSU_XLEN-1:0] rdata_q;

    // ========================================
    // Stage registers
    // ========================================

    // Stall freezes both stages in place
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            acc_q   <= '0;
            ret_q   <= '0;
            rdata_q <= '0;
        end else if (!i_stall) begin
            acc_q   <= i_rec;
            ret_q   <= acc_q;
            // SRAM word from the access in the previous cycle
            // Holds across stall since no new read is issued then
            rdata_q <= i_dmem_rdata;
        end
    end

    // ========================================
    // Retire stage outputs
    // ========================================

    assign o_rec   = ret_q;
    assign o_rdata = rdata_q;

endmodule

// ==== hw/dmem_request_former.sv ====
`timescale 1ns/100ps

`include "lsu_defines.svh"

module dmem_request_former (
    input  lsu_pkg::lsu_req_t    i_req,
    input  logic                 i_stall,
    output lsu_pkg::dmem_req_t   o_dmem,
    output lsu_pkg::access_rec_t o_rec
);

    // Byte position of the access inside its word
    logic [$clog2(`LSU_MASK_W)-1:0] offset;
    logic [2:0]                     size;
    logic                           is_st;
    // Accepted this cycle
    logic                           go;
    logic                           trap;
    logic [`LSU_MASK_W-1:0]         mask;
    logic [`LSU_XLEN-1:0]           lane_wdata;

    // ========================================
    // Decode of size, lanes and alignment
    // ========================================

    always_comb begin
        offset = i_req.addr[$clog2(`LSU_MASK_W)-1:0];
        size   = lsu_pkg::access_size(i_req.op);
        is_st  = lsu_pkg::is_store(i_req.op);
        go     = i_req.valid & ~i_stall;

        // Lane mask follows size, then slides to the byte offset
        case (size)
            3'd1:    mask = {{(`LSU_MASK_W-1){1'b0}}, 1'b1} << offset;
            3'd2:    mask = {{(`LSU_MASK_W-2){1'b0}}, 2'b11} << offset;
            default: mask = {`LSU_MASK_W{1'b1}};
        endcase

        // Halfword must sit on an even byte, word on a word boundary
        case (size)
            3'd2:    trap = offset[0];
            3'd4:    trap = (offset != '0);
            default: trap = 1'b0;
        endcase

        // Store data moves up into the addressed lanes
        lane_wdata = i_req.wdata << (offset * `LSU_BYTE_W);
    end

    // ========================================
    // Memory request
    // ========================================

    always_comb begin
        // Word aligned address, low bits cleared
        o_dmem.addr  = i_req.addr & ~(`LSU_XLEN'(`LSU_MASK_W - 1));
        o_dmem.mask  = mask;
        o_dmem.wdata = lane_wdata;
        // A trapped access never reaches the SRAM
        o_dmem.ren   = go & ~trap & ~is_st;
        o_dmem.wen   = go & ~trap & is_st;
    end

    // ========================================
    // Record for the access stage
    // ========================================

    always_comb begin
        o_rec.valid  = go;
        o_rec.op     = i_req.op;
        o_rec.offset = offset;
        o_rec.rd     = i_req.rd;
        o_rec.trap   = trap;
        // Keep the exact request issued, enables included
        o_rec.dmem   = o_dmem;
    end

endmodule

// ==== hw/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

    // ========================================
    // Opcodes
    // ========================================

    // Encoding is {store bit, funct3}
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } mem_op_e;

    // ========================================
    // Records passed between blocks
    // ========================================

    // Incoming operation from the issue side
    typedef struct packed {
        logic                       valid;
        mem_op_e                    op;
        logic [`LSU_XLEN-1:0]       addr;
        logic [`LSU_XLEN-1:0]       wdata;
        logic [`LSU_REG_ADDR_W-1:0] rd;
    } lsu_req_t;

    // Word request as seen by the data SRAM
    typedef struct packed {
        logic [`LSU_XLEN-1:0]   addr;
        logic [`LSU_MASK_W-1:0] mask;
        logic                   ren;
        logic                   wen;
        logic [`LSU_XLEN-1:0]   wdata;
    } dmem_req_t;

    // State carried through access and retire stages
    typedef struct packed {
        logic                           valid;
        mem_op_e                        op;
        logic [$clog2(`LSU_MASK_W)-1:0] offset;
        logic [`LSU_REG_ADDR_W-1:0]     rd;
        logic                           trap;
        dmem_req_t                      dmem;
    } access_rec_t;

    // Retire record, mirrors the memory transaction of the operation
    typedef struct packed {
        logic                       valid;
        logic                       trap;
        logic [`LSU_REG_ADDR_W-1:0] rd_waddr;
        logic [`LSU_XLEN-1:0]       rd_wdata;
        logic [`LSU_XLEN-1:0]       dmem_addr;
        logic [`LSU_MASK_W-1:0]     dmem_mask;
        logic                       dmem_ren;
        logic                       dmem_wen;
        logic [`LSU_XLEN-1:0]       dmem_rdata;
        logic [`LSU_XLEN-1:0]       dmem_wdata;
    } retire_t;

    // ========================================
    // Opcode helpers
    // ========================================

    function automatic logic is_store(input mem_op_e op);
        return op[3];
    endfunction

    // Bytes touched by the access: 1, 2 or 4
    function automatic logic [2:0] access_size(input mem_op_e op);
        case (op[1:0])
            2'b00:   return 3'd1;
            2'b01:   return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    function automatic logic is_signed_load(input mem_op_e op);
        return (op == OP_LB) || (op == OP_LH);
    endfunction

endpackage

// ==== hw/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ========================================
// Load/store pipeline widths
// ========================================

// Data word and address width
`define LSU_XLEN 32

// Destination register index width
`define LSU_REG_ADDR_W 5

// Byte lanes in one data word
`define LSU_MASK_W 4

// Bits in a single byte lane
`define LSU_BYTE_W 8

// Lane count is always XLEN / BYTE_W for this memory

`endif
